// File: verilog.f
+incdir+verilog
verilog/md_op_pkg.sv
verilog/md_ctrl_pkg.sv
verilog/md_unit_if.sv
verilog/shift_test_restore_divider.sv
verilog/shift_add_multiplier.sv
verilog/md_control.sv
verilog/mul_div_unit.sv
sim/mul_div_unit_tb.sv

// File: Makefile
# Verilator flow for the multiply/divide unit.
# Override any variable on the command line, e.g. make sim BUILD_DIR=out

VERILATOR  ?= verilator
TOP        ?= mul_div_unit_tb
LINT_TOP   ?= mul_div_unit
BUILD_DIR  ?= build
SEED_FLAGS ?= +verilator+seed+27
VFLAGS     ?= --assert --timing
FILELIST   ?= verilog.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/md_consts.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# the executable exits non-zero on $$fatal, so make reports a failing run.
sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/mul_div_unit_tb.sv
// the reference model uses 64-bit arithmetic, so MD_WIDTH must stay 32; the run stops at the first error.
`timescale 1ns/1ps
`include "md_consts.svh"

module mul_div_unit_tb
    import md_op_pkg::*;
    import md_ctrl_pkg::*;
();

    localparam int W          = `MD_WIDTH;
    localparam int CLK_PERIOD = 8;
    localparam int N_MUL      = 200;
    localparam int N_DIV      = 150;
    localparam int N_CORNER   = 22;
    localparam int N_PROTO    = 12;
    // a protocol run is one operation plus a quiet window, so it counts twice.
    localparam int N_OPS      = N_MUL + 2 * N_DIV + N_CORNER + 2 * N_PROTO + 2;
    localparam longint WATCHDOG_NS = longint'(N_OPS) * (2 * W + 10) * CLK_PERIOD;
    localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

    logic         CLK;
    logic         nRST;
    logic         start;
    md_op_t       op;
    logic [W-1:0] rs1;
    logic [W-1:0] rs2;
    logic         busy;
    logic         done;
    logic [W-1:0] result;

    logic [31:0]  rng_state = 32'd27;
    logic [W-1:0] last_result;
    logic         have_result;

    mul_div_unit i_mul_div_unit (
        .CLK    (CLK),
        .nRST   (nRST),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // ########################################
    // random numbers and reference model
    // ########################################

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // about a quarter of the draws are edge values.
    function automatic logic [W-1:0] draw_operand();
        logic [31:0] r;
        r = next_random();
        if (r[2:1] != 2'd0) begin
            return next_random();
        end
        case (r[4:3])
            2'd0:    return '0;
            2'd1:    return W'(1);
            2'd2:    return '1;
            default: return MOST_NEG;
        endcase
    endfunction

    // architectural result of one operation, built from 64-bit arithmetic.
    function automatic logic [W-1:0] model_result(input md_op_t o, input logic [W-1:0] a,
                                                  input logic [W-1:0] b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'd0, a};
        ub = {32'd0, b};
        p  = '0;
        case (o)
            OP_MUL, OP_MULH: p = sa * sb;
            OP_MULHSU:       p = sa * longint'(ub);
            OP_MULHU:        p = ua * ub;
            OP_DIV: begin
                if (b == '0) return '1;
                if (a == MOST_NEG && b == '1) return a;
                return W'(sa / sb);
            end
            OP_REM: begin
                if (b == '0) return a;
                if (a == MOST_NEG && b == '1) return '0;
                return W'(sa % sb);
            end
            OP_DIVU:         return (b == '0) ? '1 : W'(ua / ub);
            default:         return (b == '0) ? a : W'(ua % ub);
        endcase
        return (o == OP_MUL) ? p[31:0] : p[63:32];
    endfunction

    // ########################################
    // checks and bus tasks
    // ########################################

    task automatic check_value(input string name, input logic [W-1:0] exp,
                               input logic [W-1:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("test failed");
            $fatal(1, "protocol error");
        end
    endtask

    // one operation; poke_at > 0 pulses a stray start that many cycles into the wait.
    task automatic run_op(input string name, input md_op_t o, input logic [W-1:0] a,
                          input logic [W-1:0] b, input int poke_at,
                          output logic [W-1:0] res);
        int          cycles;
        logic [31:0] r;
        @(posedge CLK);
        #1;
        if (have_result) begin
            check_value({name, " hold"}, last_result, result);
        end
        check_true(!busy && !done, "unit was not idle before start");
        start = 1'b1;
        op    = o;
        rs1   = a;
        rs2   = b;
        @(posedge CLK);
        #1;
        // scramble the inputs so that only latched operands can give the right answer.
        start = 1'b0;
        r     = next_random();
        op    = md_op_t'(r[2:0]);
        rs1   = next_random();
        rs2   = next_random();
        check_true(busy, "busy did not rise after an accepted start");
        cycles = 0;
        while (!done) begin
            cycles++;
            start = (cycles == poke_at) && busy;
            @(posedge CLK);
            #1;
        end
        start       = 1'b0;
        res         = result;
        last_result = result;
        have_result = 1'b1;
        @(posedge CLK);
        #1;
        check_true(!done, "done stayed high for more than one cycle");
        check_true(!busy, "busy stayed high after done");
        check_value({name, " hold"}, res, result);
    endtask

    // no done, no busy and a steady result while nothing is started.
    task automatic watch_idle(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
            check_true(!busy && !done, "unit became active without an accepted start");
            if (have_result) begin
                check_value("idle hold", last_result, result);
            end
        end
    endtask

    // ########################################
    // test sequence
    // ########################################

    initial begin
        logic [31:0]  r;
        md_op_t       o;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] q;
        logic [W-1:0] rem;
        logic [W-1:0] res;
        logic         sgn;
        logic [W-1:0] dividends [5];

        nRST        = 1'b0;
        start       = 1'b0;
        op          = OP_MUL;
        rs1         = '0;
        rs2         = '0;
        have_result = 1'b0;
        @(posedge CLK);
        #1;
        check_true(!busy && !done, "busy or done high during reset");
        @(posedge CLK);
        #1;
        nRST = 1'b1;
        watch_idle(3);

        // random multiplies on all four opcodes.
        for (int i = 0; i < N_MUL; i++) begin
            r = next_random();
            o = md_op_t'({1'b0, r[1:0]});
            a = draw_operand();
            b = draw_operand();
            run_op(o.name(), o, a, b, 0, res);
            check_value(o.name(), model_result(o, a, b), res);
        end

        // random divides, quotient and remainder on the same operands.
        for (int i = 0; i < N_DIV; i++) begin
            r   = next_random();
            sgn = r[0];
            a   = draw_operand();
            b   = draw_operand();
            o   = sgn ? OP_DIV : OP_DIVU;
            run_op(o.name(), o, a, b, 0, q);
            check_value(o.name(), model_result(o, a, b), q);
            o = sgn ? OP_REM : OP_REMU;
            run_op(o.name(), o, a, b, 0, rem);
            check_value(o.name(), model_result(o, a, b), rem);
            check_value("div identity", a, q * b + rem);
            if (sgn && rem != '0) begin
                check_true(rem[W-1] == a[W-1], "remainder sign differs from dividend");
            end
        end

        // division by zero in both signednesses.
        dividends[0] = next_random();
        dividends[1] = '0;
        dividends[2] = W'(1);
        dividends[3] = '1;
        dividends[4] = MOST_NEG;
        foreach (dividends[k]) begin
            a = dividends[k];
            run_op("div by zero", OP_DIV, a, '0, 0, res);
            check_value("div by zero", '1, res);
            run_op("rem by zero", OP_REM, a, '0, 0, res);
            check_value("rem by zero", a, res);
            run_op("divu by zero", OP_DIVU, a, '0, 0, res);
            check_value("divu by zero", '1, res);
            run_op("remu by zero", OP_REMU, a, '0, 0, res);
            check_value("remu by zero", a, res);
        end

        // signed overflow.
        run_op("div overflow", OP_DIV, MOST_NEG, '1, 0, res);
        check_value("div overflow", MOST_NEG, res);
        run_op("rem overflow", OP_REM, MOST_NEG, '1, 0, res);
        check_value("rem overflow", '0, res);

        // stray starts while busy, then a quiet window that must stay idle.
        for (int i = 0; i < N_PROTO; i++) begin
            r = next_random();
            o = md_op_t'(r[2:0]);
            a = draw_operand();
            b = draw_operand();
            run_op("protocol", o, a, b, 1 + int'(r[5:3]), res);
            check_value("protocol", model_result(o, a, b), res);
            watch_idle(2 * W + 10);
        end

        $display("test passed");
        $finish;
    end

    // ########################################
    // watchdog
    // ########################################

    initial begin
        md_ctrl_state_t st;
        #(WATCHDOG_NS);
        st = i_mul_div_unit.i_md_control.state;
        $display("watchdog expired with the control FSM in %s", st.name());
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

// File: verilog/mul_div_unit.sv
// one operation at a time with no back-pressure; take result at done or before the next start.
`timescale 1ns/1ps
`include "md_consts.svh"

module mul_div_unit
    import md_op_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 start,
    input  md_op_t               op,
    input  logic [`MD_WIDTH-1:0] rs1,
    input  logic [`MD_WIDTH-1:0] rs2,
    output logic                 busy,
    output logic                 done,
    output logic [`MD_WIDTH-1:0] result
);

    // one bundle per datapath block.
    md_unit_if mul_if ();
    md_unit_if div_if ();

    // ########################################
    // control
    // ########################################

    md_control i_md_control (
        .CLK    (CLK),
        .nRST   (nRST),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result),
        .mul_u  (mul_if.ctrl),
        .div_u  (div_if.ctrl)
    );

    // ########################################
    // datapath blocks
    // ########################################

    shift_add_multiplier i_shift_add_multiplier (
        .CLK  (CLK),
        .nRST (nRST),
        .u    (mul_if.unit)
    );

    shift_test_restore_divider i_shift_test_restore_divider (
        .CLK  (CLK),
        .nRST (nRST),
        .u    (div_if.unit)
    );

endmodule

// File: verilog/md_control.sv
// starts are ignored while busy; result holds from done until the next accepted start.
`timescale 1ns/1ps
`include "md_consts.svh"

module md_control
    import md_op_pkg::*;
    import md_ctrl_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 start,
    input  md_op_t               op,
    input  logic [`MD_WIDTH-1:0] rs1,
    input  logic [`MD_WIDTH-1:0] rs2,
    output logic                 busy,
    output logic                 done,
    output logic [`MD_WIDTH-1:0] result,
    md_unit_if.ctrl              mul_u,
    md_unit_if.ctrl              div_u
);

    md_ctrl_state_t       state;
    md_op_t               op_q;
    logic [`MD_WIDTH-1:0] a_q;
    logic [`MD_WIDTH-1:0] b_q;
    logic                 div_zero;
    logic                 settle;
    logic                 op_is_div;
    md_op_class_t         cls;
    md_sel_t              sel;
    logic                 unit_finished;
    logic [`MD_WIDTH-1:0] unit_lo;
    logic [`MD_WIDTH-1:0] unit_hi;
    logic [`MD_WIDTH-1:0] next_result;

    // ########################################
    // opcode decode
    // ########################################

    // the incoming opcode is only checked for the zero-divisor shortcut.
    assign op_is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    // everything else decodes from the latched opcode.
    always_comb begin
        cls = '{unit: UNIT_MUL, a_signed: 1'b0, b_signed: 1'b0};
        sel = SEL_HI;
        case (op_q)
            OP_MUL:    begin cls = '{UNIT_MUL, 1'b1, 1'b1}; sel = SEL_LO; end
            OP_MULH:   cls = '{UNIT_MUL, 1'b1, 1'b1};
            OP_MULHSU: cls = '{UNIT_MUL, 1'b1, 1'b0};
            OP_MULHU:  cls = '{UNIT_MUL, 1'b0, 1'b0};
            OP_DIV:    begin cls = '{UNIT_DIV, 1'b1, 1'b1}; sel = SEL_LO; end
            OP_DIVU:   begin cls = '{UNIT_DIV, 1'b0, 1'b0}; sel = SEL_LO; end
            OP_REM:    cls = '{UNIT_DIV, 1'b1, 1'b1};
            OP_REMU:   cls = '{UNIT_DIV, 1'b0, 1'b0};
            default:   sel = SEL_HI;
        endcase
    end

    // ########################################
    // sequencing FSM
    // ########################################

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= ST_IDLE;
            done     <= 1'b0;
            div_zero <= 1'b0;
            settle   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        // a zero divisor skips the divider entirely.
                        div_zero <= op_is_div && (rs2 == '0);
                        state    <= (op_is_div && (rs2 == '0)) ? ST_DONE : ST_LAUNCH;
                    end
                end
                ST_LAUNCH: begin
                    settle <= 1'b1;
                    state  <= ST_WAIT;
                end
                ST_WAIT: begin
                    // finished is ignored on the first wait cycle after the pulse.
                    settle <= 1'b0;
                    if (!settle && unit_finished) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operands are latched once per accepted start and result once per done.
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && start) begin
            op_q <= op;
            a_q  <= rs1;
            b_q  <= rs2;
        end
        if (state == ST_DONE) begin
            result <= next_result;
        end
    end

    // ########################################
    // unit ports and result select
    // ########################################

    assign unit_finished = (cls.unit == UNIT_DIV) ? div_u.finished : mul_u.finished;
    assign unit_lo       = (cls.unit == UNIT_DIV) ? div_u.lo : mul_u.lo;
    assign unit_hi       = (cls.unit == UNIT_DIV) ? div_u.hi : mul_u.hi;

    // division by zero: quotient all ones, remainder equals the dividend.
    always_comb begin
        if (div_zero) begin
            next_result = (sel == SEL_LO) ? '1 : a_q;
        end else begin
            next_result = (sel == SEL_LO) ? unit_lo : unit_hi;
        end
    end

    // both units see the same operands; only the chosen one gets the pulse.
    assign mul_u.start    = (state == ST_LAUNCH) && (cls.unit == UNIT_MUL);
    assign mul_u.op_a     = a_q;
    assign mul_u.op_b     = b_q;
    assign mul_u.a_signed = cls.a_signed;
    assign mul_u.b_signed = cls.b_signed;
    assign div_u.start    = (state == ST_LAUNCH) && (cls.unit == UNIT_DIV);
    assign div_u.op_a     = a_q;
    assign div_u.op_b     = b_q;
    assign div_u.a_signed = cls.a_signed;
    assign div_u.b_signed = cls.b_signed;

    assign busy = (state != ST_IDLE);

endmodule

// File: verilog/shift_add_multiplier.sv
// each operand takes its own sign flag; the full double-width product is kept.
`timescale 1ns/1ps
`include "md_consts.svh"

module shift_add_multiplier (
    input logic     CLK,
    input logic     nRST,
    md_unit_if.unit u
);

    localparam int W = `MD_WIDTH;

    logic [W-1:0]            mcand_mag;
    logic [W-1:0]            mplier_mag;
    logic                    neg_prod;
    logic [W:0]              partial;
    logic [2*W-1:0]          prod;
    logic [`MD_CNT_BITS-1:0] count;
    logic                    fix_pending;
    logic                    finished;

    // ########################################
    // operand magnitudes
    // ########################################

    // magnitudes are formed per operand, so MULHSU reads op_b as unsigned.
    assign mcand_mag  = (u.a_signed && u.op_a[W-1]) ? -u.op_a : u.op_a;
    assign mplier_mag = (u.b_signed && u.op_b[W-1]) ? -u.op_b : u.op_b;

    // the product is negative when exactly one signed operand is negative.
    assign neg_prod = (u.a_signed && u.op_a[W-1]) ^ (u.b_signed && u.op_b[W-1]);

    // upper half plus the multiplicand when the current multiplier bit is set.
    // the carry lands in the extra top bit and is shifted down next.
    assign partial = {1'b0, prod[2*W-1:W]} + (prod[0] ? {1'b0, mcand_mag} : '0);

    // ########################################
    // sequencing
    // ########################################

    // one cycle per multiplier bit, then one cycle for the sign fix.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count       <= '0;
            fix_pending <= 1'b0;
            finished    <= 1'b0;
        end else if (u.start) begin
            count       <= `MD_CNT_BITS'(W);
            fix_pending <= 1'b1;
            finished    <= 1'b0;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end else if (fix_pending) begin
            fix_pending <= 1'b0;
            finished    <= 1'b1;
        end
    end

    // ########################################
    // product register
    // ########################################

    // the multiplier starts in the low half and is consumed from bit 0 upward.
    always_ff @(posedge CLK) begin
        if (u.start) begin
            prod <= {{W{1'b0}}, mplier_mag};
        end else if (count != '0) begin
            prod <= {partial, prod[W-1:1]};
        end else if (fix_pending && neg_prod) begin
            // two's complement over the whole double-width product.
            prod <= -prod;
        end
    end

    assign u.lo       = prod[W-1:0];
    assign u.hi       = prod[2*W-1:W];
    assign u.finished = finished;

endmodule

// File: verilog/shift_test_restore_divider.sv
// signedness comes from a_signed only; a zero divisor must be caught before this block.
`timescale 1ns/1ps
`include "md_consts.svh"

module shift_test_restore_divider (
    input logic     CLK,
    input logic     nRST,
    md_unit_if.unit u
);

    localparam int W = `MD_WIDTH;

    logic [W-1:0]             dividend_mag;
    logic [W-1:0]             divisor_mag;
    logic                     neg_quo;
    logic                     neg_rem;
    logic [W+1:0]             rem;
    logic [W-1:0]             quo;
    logic [`MD_CNT_BITS-1:0]  count;
    logic                     test_phase;
    logic                     adjust_pending;
    logic                     finished;

    // ########################################
    // operand magnitudes and result signs
    // ########################################

    // the operands are held steady by control, so these can stay combinational.
    // the most negative value maps onto its own unsigned pattern, which is correct.
    assign dividend_mag = (u.a_signed && u.op_a[W-1]) ? -u.op_a : u.op_a;
    assign divisor_mag  = (u.a_signed && u.op_b[W-1]) ? -u.op_b : u.op_b;

    // the quotient is negative when the operand signs differ.
    assign neg_quo = u.a_signed && (u.op_a[W-1] ^ u.op_b[W-1]);
    // the remainder follows the sign of the dividend.
    assign neg_rem = u.a_signed && u.op_a[W-1];

    // ########################################
    // iteration control
    // ########################################

    // each bit takes two cycles, and one more cycle fixes the signs.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count          <= '0;
            test_phase     <= 1'b0;
            adjust_pending <= 1'b0;
            finished       <= 1'b0;
        end else if (u.start) begin
            count          <= `MD_CNT_BITS'(W);
            test_phase     <= 1'b0;
            adjust_pending <= 1'b1;
            finished       <= 1'b0;
        end else if (count != '0) begin
            // the counter only moves on the test half of a bit.
            if (test_phase) begin
                count <= count - 1'b1;
            end
            test_phase <= ~test_phase;
        end else if (adjust_pending) begin
            adjust_pending <= 1'b0;
            finished       <= 1'b1;
        end
    end

    // ########################################
    // remainder and quotient registers
    // ########################################

    // rem carries two extra bits: one for the shifted-in bit, one for the sign.
    always_ff @(posedge CLK) begin
        if (u.start) begin
            rem <= '0;
            quo <= dividend_mag;
        end else if (count != '0) begin
            if (!test_phase) begin
                // shift the next dividend bit in and trial-subtract the divisor.
                rem <= {1'b0, rem[W-1:0], quo[W-1]} - {2'b00, divisor_mag};
                quo <= {quo[W-2:0], 1'b0};
            end else if (rem[W+1]) begin
                // the trial went negative, so undo it and keep a zero bit.
                rem <= rem + {2'b00, divisor_mag};
            end else begin
                quo[0] <= 1'b1;
            end
        end else if (adjust_pending) begin
            // final sign fix on the magnitudes.
            if (neg_quo) begin
                quo <= -quo;
            end
            if (neg_rem) begin
                rem <= {2'b00, -rem[W-1:0]};
            end
        end
    end

    assign u.lo       = quo;
    assign u.hi       = rem[W-1:0];
    assign u.finished = finished;

endmodule

// File: verilog/md_unit_if.sv
// operands and sign flags must stay stable from start until finished rises again.
`timescale 1ns/1ps
`include "md_consts.svh"

interface md_unit_if;

    // launch pulse, one cycle wide, from control.
    logic                 start;
    // operand words; for the divider op_a is the dividend and op_b the divisor.
    logic [`MD_WIDTH-1:0] op_a;
    logic [`MD_WIDTH-1:0] op_b;
    // per-operand signedness.
    logic                 a_signed;
    logic                 b_signed;
    // result halves: product low/high, or quotient/remainder.
    logic [`MD_WIDTH-1:0] lo;
    logic [`MD_WIDTH-1:0] hi;
    // level, high while lo and hi hold a valid result.
    logic                 finished;

    modport ctrl (output start, op_a, op_b, a_signed, b_signed,
                  input  lo, hi, finished);

    modport unit (input  start, op_a, op_b, a_signed, b_signed,
                  output lo, hi, finished);

endinterface

// File: verilog/md_ctrl_pkg.sv
// control FSM and result-select encodings; both enums are 2 bits wide.
package md_ctrl_pkg;

    // states of the sequencing FSM in the control block.
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LAUNCH = 2'd1,
        ST_WAIT   = 2'd2,
        ST_DONE   = 2'd3
    } md_ctrl_state_t;

    // which half of the unit output becomes the result.
    typedef enum logic [1:0] {
        SEL_LO = 2'd0,
        SEL_HI = 2'd1
    } md_sel_t;

endpackage

// File: verilog/md_op_pkg.sv
// opcode encodings follow the M-extension funct3 order; the enum width is fixed at 3 bits.
package md_op_pkg;

    // the eight multiply and divide operations, in funct3 order.
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } md_op_t;

    // which datapath block serves an opcode.
    typedef enum logic {
        UNIT_MUL = 1'b0,
        UNIT_DIV = 1'b1
    } md_unit_sel_t;

    // decoded class of an opcode: the unit and how each operand is read.
    typedef struct packed {
        md_unit_sel_t unit;
        logic         a_signed;
        logic         b_signed;
    } md_op_class_t;

endpackage

// File: verilog/md_consts.svh
// width and iteration macros; MD_CNT_BITS must be able to hold the value MD_WIDTH.
`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// ########################################
// datapath sizing
// ########################################

// operand and result width of the unit, in bits.
`define MD_WIDTH 32

// width of the per-bit iteration counters in both datapath blocks.
// six bits reach 32, which is the first count loaded after a start.
`define MD_CNT_BITS 6

`endif
